// File: tests/capture_tests.txt
# name op addr value expect, all numbers in hex
# W: write value, expect=resp | R: value=resp, expect=data | F: addr=frames
# P: addr=lines, value=vsync header | C: window words from addr, value=count
reset_status R 4 0 0
reset_count R 8 0 0
reset_ctrl R 0 0 0
enable_on W 0 1 0
ctrl_readback R 0 0 1
first_frame F 1 0 0
first_count R 8 0 780
first_status R 4 0 1
first_window C 0 780 0
status_readonly W 4 1 2
enable_off W 0 0 0
off_status R 4 0 0
off_count R 8 0 0
partial_head P 18 1 0
mid_enable W 0 1 0
partial_tail P 18 0 0
partial_count R 8 0 0
partial_status R 4 0 0
second_frame F 1 0 0
second_count R 8 0 780
frame_three F 1 0 0
third_status R 4 0 1
fill_frames F 2 0 0
full_count R 8 0 1680
full_status R 4 0 3
full_window C 0 1680 0
past_window R da00 2 0
disable_again W 0 0 0
clear_status R 4 0 0
clear_count R 8 0 0
reenable W 0 1 0
fresh_frame F 1 0 0
fresh_count R 8 0 780
fresh_window C 0 780 0

// File: verilog.f
hdl/video_pkg.sv
hdl/sync_qualifier.sv
hdl/rgb_logic.sv
hdl/frame_ram.sv
hdl/ctrl_regs.sv
hdl/capture_top.sv
tests/capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= capture_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
PASS_MSG ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/capture_tb.sv
`timescale 1ns/1ns
module capture_tb import video_pkg::*; ();

    // Video timing of the generator
    localparam int hsync_cycles = 8;
    localparam int vsync_drop = 4;
    localparam int vsync_lines = 3;
    localparam int line_cycles = image_width + hsync_cycles;
    localparam int reset_cycles = 10;
    localparam int bus_op_cycles = 200;

    logic rgb_clk;
    logic nrst;
    logic [23:0] rgb;
    logic hsync;
    logic vsync;
    logic [axi_addr_w-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [axi_data_w-1:0] wdata;
    logic [axi_data_w/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [axi_addr_w-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [axi_data_w-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic stream_ready;

    // Test table from the data file
    string t_name[$];
    byte t_op[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_val[$];
    logic [31:0] t_exp[$];

    // Reference model state
    logic [15:0] model_mem [ram_depth];
    logic model_enable;
    logic model_armed;
    logic prev_vsync;
    int model_count;
    int seed;
    int cycle_count;
    int cycle_limit = 0;

    capture_top capture_top_i (
        .rgb_clk      (rgb_clk),
        .nrst         (nrst),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .stream_ready (stream_ready)
    );

    initial begin
        rgb_clk = 1'b0;
        forever #20 rgb_clk = ~rgb_clk;
    end

    task automatic stop_with_failure;
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Bus response, SLVERR gets its own message
    task automatic expect_response(input string name, input logic [1:0] expected,
                                   input logic [1:0] actual);
        if (actual == resp_slverr && expected != resp_slverr) begin
            $display("Test %s got a SLVERR response that it did not expect", name);
            stop_with_failure();
        end else begin
            check_value(name, 32'(expected), 32'(actual));
        end
    endtask

    // Hang guard over the whole run
    always @(posedge rgb_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    task automatic load_tests;
        int fd;
        int n;
        string line;
        string name;
        string op;
        logic [31:0] a;
        logic [31:0] v;
        logic [31:0] e;
        fd = $fopen("tests/capture_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tests/capture_tests.txt");
            stop_with_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip comments and blank lines
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", name, op, a, v, e);
                    if (n == 5) begin
                        t_name.push_back(name);
                        t_op.push_back(op.getc(0));
                        t_addr.push_back(a);
                        t_val.push_back(v);
                        t_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Frame cycles plus a fixed budget per bus access
    task automatic set_cycle_limit;
        int frame_cycles;
        int bus_ops;
        frame_cycles = 0;
        bus_ops = 0;
        foreach (t_op[i]) begin
            case (t_op[i])
                "F": frame_cycles += int'(t_addr[i]) * (vsync_lines + image_height) * line_cycles;
                "P": frame_cycles += (int'(t_addr[i]) + (t_val[i][0] ? vsync_lines : 0))
                                     * line_cycles;
                "C": bus_ops += int'(t_val[i]);
                default: bus_ops += 1;
            endcase
        end
        cycle_limit = reset_cycles + frame_cycles + bus_op_cycles * bus_ops;
    endtask

    task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                             output logic [1:0] resp);
        logic aw_hit;
        logic w_hit;
        @(posedge rgb_clk);
        #2;
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = '1;
        wvalid = 1'b1;
        bready = 1'b1;
        // Handshakes judged mid-cycle, dropped after the edge
        while (awvalid || wvalid) begin
            @(negedge rgb_clk);
            aw_hit = awvalid && awready;
            w_hit = wvalid && wready;
            @(posedge rgb_clk);
            #2;
            if (aw_hit) awvalid = 1'b0;
            if (w_hit) wvalid = 1'b0;
        end
        @(negedge rgb_clk);
        while (!bvalid) @(negedge rgb_clk);
        resp = bresp;
        @(posedge rgb_clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [axi_data_w-1:0] data,
                            output logic [1:0] resp);
        logic ar_hit;
        @(posedge rgb_clk);
        #2;
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b1;
        while (arvalid) begin
            @(negedge rgb_clk);
            ar_hit = arready;
            @(posedge rgb_clk);
            #2;
            if (ar_hit) arvalid = 1'b0;
        end
        @(negedge rgb_clk);
        while (!rvalid) @(negedge rgb_clk);
        data = rdata;
        resp = rresp;
        @(posedge rgb_clk);
        #2;
        rready = 1'b0;
    endtask

    // Model follows the arm, full and clear rules
    task automatic capture_model(input logic [23:0] pix);
        if (model_armed && model_count < ram_depth) begin
            model_mem[ram_addr_w'(model_count)] = {pix[23:19], pix[15:10], pix[7:3]};
            model_count++;
        end
    endtask

    task automatic update_enable(input logic en);
        model_enable = en;
        if (!en) begin
            model_armed = 1'b0;
            model_count = 0;
        end
    endtask

    task automatic drive_cycle(input logic h, input logic v);
        logic [31:0] rnd;
        @(posedge rgb_clk);
        #2;
        rnd = $random(seed);
        rgb = rnd[23:0];
        hsync = h;
        vsync = v;
        // Falling vsync arms an enabled capture
        if (prev_vsync && !v && model_enable) model_armed = 1'b1;
        prev_vsync = v;
        if (!h && !v) capture_model(rnd[23:0]);
    endtask

    // Pixels, then hsync; vsync may drop late in the hsync pulse
    task automatic drive_line(input logic v, input logic v_end);
        repeat (image_width) drive_cycle(1'b0, v);
        repeat (hsync_cycles - vsync_drop) drive_cycle(1'b1, v);
        repeat (vsync_drop) drive_cycle(1'b1, v_end);
    endtask

    task automatic drive_partial(input int lines, input logic header);
        int k;
        if (header) begin
            for (k = 0; k < vsync_lines; k++) begin
                drive_line(1'b1, k != vsync_lines - 1);
            end
        end
        repeat (lines) drive_line(1'b0, 1'b0);
    endtask

    task automatic compare_window(input string name, input int first, input int words);
        int j;
        logic [axi_addr_w-1:0] addr;
        logic [axi_data_w-1:0] data;
        logic [1:0] resp;
        for (j = first; j < first + words; j++) begin
            addr = ram_window_base + axi_addr_w'(4 * j);
            axi_read(addr, data, resp);
            expect_response($sformatf("%s word %0d", name, j), resp_okay, resp);
            check_value($sformatf("%s word %0d", name, j), 32'(model_mem[ram_addr_w'(j)]), data);
        end
    endtask

    task automatic run_test(input int i);
        logic [axi_data_w-1:0] data;
        logic [1:0] resp;
        case (t_op[i])
            "W": begin
                axi_write(t_addr[i][axi_addr_w-1:0], t_val[i], resp);
                expect_response(t_name[i], t_exp[i][1:0], resp);
                if (t_addr[i][axi_addr_w-1:0] == reg_ctrl && resp == resp_okay) begin
                    update_enable(t_val[i][0]);
                end
            end
            "R": begin
                axi_read(t_addr[i][axi_addr_w-1:0], data, resp);
                expect_response(t_name[i], t_val[i][1:0], resp);
                if (resp == resp_okay) begin
                    check_value(t_name[i], t_exp[i], data);
                end
                // Status bit 0 mirrors the port
                if (t_addr[i][axi_addr_w-1:0] == reg_status && resp == resp_okay) begin
                    check_value({t_name[i], " port"}, 32'(t_exp[i][0]), 32'(stream_ready));
                end
            end
            "F": repeat (t_addr[i]) drive_partial(image_height, 1'b1);
            "P": drive_partial(int'(t_addr[i]), t_val[i][0]);
            "C": compare_window(t_name[i], int'(t_addr[i]), int'(t_val[i]));
            default: begin
                $display("Unknown op %c in test %s", t_op[i], t_name[i]);
                stop_with_failure();
            end
        endcase
    endtask

    initial begin
        nrst = 1'b0;
        rgb = '0;
        hsync = 1'b1;
        vsync = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        seed = 96;
        cycle_count = 0;
        model_enable = 1'b0;
        model_armed = 1'b0;
        prev_vsync = 1'b0;
        model_count = 0;
        load_tests();
        set_cycle_limit();
        repeat (reset_cycles) @(posedge rgb_clk);
        #2;
        nrst = 1'b1;
        foreach (t_op[i]) begin
            run_test(i);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: hdl/capture_top.sv
`timescale 1ns/1ns
module capture_top import video_pkg::*; (
    input  logic                    rgb_clk,
    input  logic                    nrst,
    // Parallel video
    input  logic [23:0]             rgb,
    input  logic                    hsync,
    input  logic                    vsync,
    // AXI4-Lite slave
    input  logic [axi_addr_w-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [axi_data_w-1:0]   wdata,
    input  logic [axi_data_w/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [axi_addr_w-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [axi_data_w-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Status
    output logic                    stream_ready
);

    video_stage_t stage1;
    ram_write_t ram_wr;
    logic capture_enable;
    logic [ram_addr_w:0] write_count;
    logic [ram_addr_w-1:0] ram_rd_addr;
    pixel_word_t ram_rd_data;

    sync_qualifier sync_qualifier_i (
        .rgb_clk   (rgb_clk),
        .nrst      (nrst),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .stage_out (stage1)
    );

    rgb_logic rgb_logic_i (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .stage_in       (stage1),
        .capture_enable (capture_enable),
        .ram_wr         (ram_wr),
        .write_count    (write_count),
        .stream_ready   (stream_ready)
    );

    frame_ram frame_ram_i (
        .rgb_clk (rgb_clk),
        .wr      (ram_wr),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    ctrl_regs ctrl_regs_i (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .capture_enable (capture_enable),
        .stream_ready   (stream_ready),
        .write_count    (write_count),
        .ram_rd_addr    (ram_rd_addr),
        .ram_rd_data    (ram_rd_data)
    );

endmodule

// File: hdl/ctrl_regs.sv
`timescale 1ns/1ns
module ctrl_regs import video_pkg::*; (
    input  logic                    rgb_clk,
    input  logic                    nrst,
    // Write address and data
    input  logic [axi_addr_w-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [axi_data_w-1:0]   wdata,
    input  logic [axi_data_w/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // Read address and data
    input  logic [axi_addr_w-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [axi_data_w-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Capture side
    output logic                    capture_enable,
    input  logic                    stream_ready,
    input  logic [ram_addr_w:0]     write_count,
    output logic [ram_addr_w-1:0]   ram_rd_addr,
    input  pixel_word_t             ram_rd_data
);

    logic aw_take;
    logic w_take;
    logic aw_held;
    logic w_held;
    logic wr_fire;
    logic wr_is_ctrl;
    logic aw_held_nx;
    logic w_held_nx;
    logic bvalid_nx;
    logic [axi_addr_w-1:0] aw_addr_q;
    logic [axi_addr_w-1:0] wr_addr;
    logic [axi_data_w-1:0] w_data_q;
    logic [axi_data_w-1:0] wr_data;
    logic [axi_data_w/8-1:0] w_strb_q;
    logic [axi_data_w/8-1:0] wr_strb;
    logic ar_take;
    logic rd_win;
    logic rd_pend;
    logic rd_reg_hit;
    logic rvalid_nx;
    logic full;
    logic [axi_addr_w-1:0] win_off;
    logic [axi_data_w-1:0] reg_rdata;

    assign aw_take = awvalid && awready;
    assign w_take = wvalid && wready;
    // Address and data may come in either order
    assign wr_fire = (aw_held || aw_take) && (w_held || w_take);
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb;
    assign wr_is_ctrl = wr_addr == reg_ctrl;
    assign aw_held_nx = (aw_held || aw_take) && !wr_fire;
    assign w_held_nx = (w_held || w_take) && !wr_fire;
    assign bvalid_nx = wr_fire || (bvalid && !bready);

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            capture_enable <= 1'b0;
        end else begin
            aw_held <= aw_held_nx;
            w_held <= w_held_nx;
            bvalid <= bvalid_nx;
            // No new write until the response is gone
            awready <= !aw_held_nx && !bvalid_nx;
            wready <= !w_held_nx && !bvalid_nx;
            // Only byte 0 of the control word is writable
            if (wr_fire && wr_is_ctrl && wr_strb[0]) begin
                capture_enable <= wr_data[0];
            end
        end
    end

    always_ff @(posedge rgb_clk) begin
        if (aw_take) begin
            aw_addr_q <= awaddr;
        end
        if (w_take) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (wr_fire) begin
            bresp <= wr_is_ctrl ? resp_okay : resp_slverr;
        end
    end

    // Read decode
    assign ar_take = arvalid && arready;
    assign full = write_count == ram_depth;
    assign win_off = araddr - ram_window_base;
    assign rd_win = (araddr >= ram_window_base) && (win_off < ram_depth * 4)
                    && (win_off[1:0] == 2'b00);
    // RAM samples this on the handshake edge
    assign ram_rd_addr = win_off[ram_addr_w+1:2];

    always_comb begin
        rd_reg_hit = 1'b1;
        reg_rdata = '0;
        case (araddr)
            reg_ctrl: reg_rdata[0] = capture_enable;
            reg_status: reg_rdata[1:0] = {full, stream_ready};
            reg_count: reg_rdata[ram_addr_w:0] = write_count;
            default: rd_reg_hit = 1'b0;
        endcase
    end

    // Window reads spend one extra cycle in the RAM
    assign rvalid_nx = (ar_take && !rd_win) || rd_pend || (rvalid && !rready);

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            rd_pend <= 1'b0;
            rvalid <= 1'b0;
            arready <= 1'b0;
        end else begin
            rd_pend <= ar_take && rd_win;
            rvalid <= rvalid_nx;
            arready <= !(ar_take && rd_win) && !rvalid_nx;
        end
    end

    always_ff @(posedge rgb_clk) begin
        if (ar_take && !rd_win) begin
            rdata <= reg_rdata;
            rresp <= rd_reg_hit ? resp_okay : resp_slverr;
        end else if (rd_pend) begin
            rdata <= axi_data_w'(ram_rd_data.raw);
            rresp <= resp_okay;
        end
    end

    a_rvalid_held: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        rvalid && !rready |=> rvalid
    );

    a_bvalid_held: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        bvalid && !bready |=> bvalid
    );

endmodule

// File: hdl/frame_ram.sv
`timescale 1ns/1ns
module frame_ram import video_pkg::*; (
    input  logic                  rgb_clk,
    input  ram_write_t            wr,
    input  logic [ram_addr_w-1:0] rd_addr,
    output pixel_word_t           rd_data
);

    pixel_word_t mem [ram_depth];

    // Capture side
    always_ff @(posedge rgb_clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Bus side, one cycle latency
    // Same-address collision returns the old word
    always_ff @(posedge rgb_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/rgb_logic.sv
`timescale 1ns/1ns
module rgb_logic import video_pkg::*; (
    input  logic                rgb_clk,
    input  logic                nrst,
    input  video_stage_t        stage_in,
    input  logic                capture_enable,
    output ram_write_t          ram_wr,
    output logic [ram_addr_w:0] write_count,
    output logic                stream_ready
);

    logic armed;
    logic room;
    logic take_pixel;
    logic [ram_addr_w:0] count;
    logic wr_en;
    logic [ram_addr_w-1:0] wr_addr;
    pixel_word_t wr_data;

    // Count doubles as the next write address
    assign room = count < ram_depth;
    assign take_pixel = armed && stage_in.active && room;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            armed <= 1'b0;
            count <= '0;
            wr_en <= 1'b0;
            stream_ready <= 1'b0;
        end else if (!capture_enable) begin
            // Disable throws away the whole capture state
            armed <= 1'b0;
            count <= '0;
            wr_en <= 1'b0;
            stream_ready <= 1'b0;
        end else begin
            // Wait for a clean frame boundary
            if (stage_in.frame_start) begin
                armed <= 1'b1;
            end
            wr_en <= take_pixel;
            if (take_pixel) begin
                count <= count + 1'b1;
            end
            // Sticky once enough frames are in
            stream_ready <= stream_ready || (count >= slices_before_stream * image_size);
        end
    end

    // Address and pixel ride along with wr_en
    always_ff @(posedge rgb_clk) begin
        wr_addr <= count[ram_addr_w-1:0];
        // Plain truncation to RGB565
        wr_data.fields.red <= stage_in.rgb[23:19];
        wr_data.fields.green <= stage_in.rgb[15:10];
        wr_data.fields.blue <= stage_in.rgb[7:3];
    end

    assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign write_count = count;

    a_addr_in_range: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        ram_wr.en |-> (ram_wr.addr < ram_depth)
    );

    a_ready_needs_enable: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        !capture_enable |=> !stream_ready
    );

endmodule

// File: hdl/sync_qualifier.sv
`timescale 1ns/1ns
module sync_qualifier import video_pkg::*; (
    input  logic         rgb_clk,
    input  logic         nrst,
    input  logic [23:0]  rgb,
    input  logic         hsync,
    input  logic         vsync,
    output video_stage_t stage_out
);

    logic [23:0] rgb_q;
    logic active_q;
    logic start_q;
    logic vsync_q;

    // Colour is payload only
    always_ff @(posedge rgb_clk) begin
        rgb_q <= rgb;
    end

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            active_q <= 1'b0;
            start_q <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            // Either sync high means blanking
            active_q <= !hsync && !vsync;
            // Vsync falling edge opens a new frame
            start_q <= vsync_q && !vsync;
            vsync_q <= vsync;
        end
    end

    assign stage_out = '{rgb: rgb_q, active: active_q, frame_start: start_q};

    // Vsync must fall inside horizontal blanking
    // so the frame start never lands on a pixel
    a_start_not_active: assert property (
        @(posedge rgb_clk) disable iff (!nrst)
        !(stage_out.active && stage_out.frame_start)
    );

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

    // Frame geometry
    localparam int image_width = 40;
    localparam int image_height = 48;
    localparam int image_size = image_width * image_height;

    // Buffer holds a few whole frames
    localparam int image_in_ram = 3;
    localparam int ram_depth = image_size * image_in_ram;
    localparam int ram_addr_w = 13;

    // Frames stored before the display side may start
    localparam int slices_before_stream = 1;

    // AXI4-Lite bus widths
    localparam int axi_addr_w = 16;
    localparam int axi_data_w = 32;

    // Register map, byte offsets
    localparam logic [axi_addr_w-1:0] reg_ctrl = 16'h0000;
    localparam logic [axi_addr_w-1:0] reg_status = 16'h0004;
    localparam logic [axi_addr_w-1:0] reg_count = 16'h0008;
    // One buffer word per 32-bit bus word from here on
    localparam logic [axi_addr_w-1:0] ram_window_base = 16'h8000;

    // Response codes
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Capture fills the colour fields, the bus reads the raw word
    typedef union packed {
        rgb565_t fields;
        logic [15:0] raw;
    } pixel_word_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic active;
        logic frame_start;
    } video_stage_t;

    typedef struct packed {
        logic en;
        logic [ram_addr_w-1:0] addr;
        pixel_word_t data;
    } ram_write_t;

endpackage
